// File: all.f
src/scope_pkg.sv
src/adc_capture.sv
src/window_stats.sv
src/report_framer.sv
src/uart_tx.sv
src/scope_top.sv
dv/uart_monitor.sv
dv/scope_tb.sv

// File: dv/scope_tb.sv
module scope_tb
    import scope_pkg::*;
();

    localparam int WINDOW_LEN     = 16;
    localparam int CLKS_PER_BIT   = 4;
    localparam int NUM_ROWS       = 6;
    localparam int FRAME_CYCLES   = FRAME_BYTES * 10 * CLKS_PER_BIT;
    localparam int TIMEOUT_CYCLES = 3 * NUM_ROWS * (WINDOW_LEN + FRAME_CYCLES);

    typedef struct packed {
        adc_raw_t    start;
        adc_raw_t    step;
        logic [31:0] gate_mask;     // Bit i gates sample i modulo 32
        logic        back_to_back;  // Two windows with no pause
        logic        random_codes;
    } row_t;

    typedef logic [FRAME_BYTES*8-1:0] frame_t;

    logic     clock = 1'b0;
    logic     reset;
    logic     gate;
    adc_raw_t adc_data;
    logic     tx;
    logic     led_r;
    logic     led_g;
    logic     led_b;

    frame_t   frame;
    int       frame_count;
    int       byte_count;
    int       framing_errors;
    logic     in_frame;

    row_t     rows [NUM_ROWS];
    frame_t   expected [$];
    int       seed   = 76;
    int       errors = 0;
    int       checks = 0;
    int       cycles = 0;

    scope_top #(
        .WINDOW_LEN   (WINDOW_LEN),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) UUT (
        .i_clock    (clock),
        .i_reset    (reset),
        .i_gate     (gate),
        .i_adc_data (adc_data),
        .o_tx_ch1   (tx),
        .o_led0_r   (led_r),
        .o_led0_g   (led_g),
        .o_led0_b   (led_b)
    );

    uart_monitor #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_monitor (
        .i_clock          (clock),
        .i_reset          (reset),
        .i_rx             (tx),
        .o_frame          (frame),
        .o_frame_count    (frame_count),
        .o_byte_count     (byte_count),
        .o_framing_errors (framing_errors),
        .o_in_frame       (in_frame)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d errors so far", cycles, errors);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    // Blue and green LEDs while the monitor sees a frame
    always @(posedge clock) begin
        #2;
        if (!reset && in_frame) begin
            check_value("o_led0_b", 1, 64'(led_b));
            check_value("o_led0_g", 0, 64'(led_g));
        end
    end

    function automatic int floor_mean(input int sum, input int n);
        if (sum >= 0) begin
            return sum / n;
        end
        return -((-sum + n - 1) / n);
    endfunction

    function automatic frame_t make_frame(input int min_v, input int max_v, input int mean_v);
        return {FRAME_HEADER, min_v[15:0], max_v[15:0], mean_v[15:0]};
    endfunction

    task automatic apply_row(input row_t row);
        adc_raw_t code;
        int       value;
        int       min_v;
        int       max_v;
        int       sum;
        int       gated;
        int       i;
        gated = 0;
        i     = 0;
        while (gated < (row.back_to_back ? 2 : 1) * WINDOW_LEN) begin
            @(posedge clock);
            #1;
            if (row.random_codes) begin
                code = adc_raw_t'($random(seed));
            end else begin
                code = row.start + row.step * adc_raw_t'(i);
            end
            adc_data = code;
            gate     = row.gate_mask[i % 32];
            if (gate) begin
                value = int'(code) - 8192;      // Mid-scale code is zero
                if (gated % WINDOW_LEN == 0) begin
                    min_v = value;
                    max_v = value;
                    sum   = 0;
                end
                min_v = (value < min_v) ? value : min_v;
                max_v = (value > max_v) ? value : max_v;
                sum   += value;
                gated++;
                if (gated == WINDOW_LEN) begin  // Second window of a pair is dropped
                    expected.push_back(make_frame(min_v, max_v, floor_mean(sum, WINDOW_LEN)));
                end
            end
            i++;
        end
        @(posedge clock);
        #1;
        gate = 1'b0;
    endtask

    task automatic wait_frame(input int seen);
        int waited;
        waited = 0;
        while (frame_count == seen && waited < 2 * FRAME_CYCLES) begin
            @(posedge clock);
            #1;
            waited++;
        end
        assert (frame_count > seen) else begin
            errors++;
            $display("No frame arrived within %0d cycles at %0t", waited, $time);
        end
    endtask

    task automatic wait_sending_done();
        int waited;
        waited = 0;
        while (led_b && waited < 3 * CLKS_PER_BIT) begin
            @(posedge clock);
            #1;
            waited++;
        end
        check_value("o_led0_b", 0, 64'(led_b));
    endtask

    initial begin
        int   seen;
        logic dropped;
        rows[0] = '{14'h2005, 14'h0003, 32'hFFFF_FFFF, 1'b0, 1'b0};   // Ramp
        rows[1] = '{14'h1F80, 14'h0005, 32'hFFFF_FFFF, 1'b0, 1'b0};   // Below mid-scale
        rows[2] = '{14'h1000, 14'h0101, 32'h0FF0_0FF0, 1'b0, 1'b0};   // Gate gaps
        rows[3] = '{14'h0000, 14'h0000, 32'hFFFF_FFFF, 1'b0, 1'b1};
        rows[4] = '{14'h0000, 14'h0000, 32'hAAAA_AAAA, 1'b0, 1'b1};
        rows[5] = '{14'h3F00, 14'h3FFF, 32'hFFFF_FFFF, 1'b1, 1'b0};   // Overflow pair
        dropped  = 1'b0;
        reset    = 1'b1;
        gate     = 1'b0;
        adc_data = '0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value("o_tx_ch1", 1, 64'(tx));
        check_value("o_led0_r", 0, 64'(led_r));
        check_value("o_led0_g", 1, 64'(led_g));
        check_value("o_led0_b", 0, 64'(led_b));

        for (int r = 0; r < NUM_ROWS; r++) begin
            seen = frame_count;
            apply_row(rows[r]);
            if (r == 0) begin
                check_value("in_frame", 0, 64'(in_frame));
            end
            wait_frame(seen);
            check_value("frame", expected.pop_front(), 64'(frame));
            wait_sending_done();
            dropped = dropped || rows[r].back_to_back;
            check_value("o_led0_r", 64'(dropped), 64'(led_r));
            check_value("o_led0_g", 64'(!dropped), 64'(led_g));
        end

        // Dropped window must never show up
        seen = frame_count;
        repeat (2 * FRAME_CYCLES) @(posedge clock);
        #1;
        check_value("frame count", 64'(seen), 64'(frame_count));
        check_value("o_led0_r", 1, 64'(led_r));

        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_value("o_led0_r", 0, 64'(led_r));
        check_value("o_led0_g", 1, 64'(led_g));
        check_value("o_tx_ch1", 1, 64'(tx));
        check_value("framing errors", 0, 64'(framing_errors));
        check_value("bytes received", 64'(FRAME_BYTES * frame_count), 64'(byte_count));
        check_value("frames received", 64'(NUM_ROWS), 64'(frame_count));

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: dv/uart_monitor.sv
module uart_monitor
    import scope_pkg::*;
#(
    parameter int CLKS_PER_BIT = 4
)
(
    input  logic                     i_clock,
    input  logic                     i_reset,
    input  logic                     i_rx,

    output logic [FRAME_BYTES*8-1:0] o_frame,
    output int                       o_frame_count,
    output int                       o_byte_count,
    output int                       o_framing_errors,
    output logic                     o_in_frame
);

    byte_t                     rx_byte;
    logic                      rx_ok;
    logic [FRAME_BYTES*8-1:0]  frame_shift;
    int                        byte_idx;

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge i_clock);
    endtask

    // Called one half cycle into the start bit
    task automatic receive_byte(output byte_t data, output logic ok);
        ok = 1'b1;
        wait_cycles(CLKS_PER_BIT / 2);          // Middle of start bit
        if (i_rx !== 1'b0) begin
            ok = 1'b0;
        end
        for (int b = 0; b < 8; b++) begin
            wait_cycles(CLKS_PER_BIT);
            data[b] = i_rx;                     // LSB first
        end
        wait_cycles(CLKS_PER_BIT);
        if (i_rx !== 1'b1) begin
            ok = 1'b0;                          // Bad stop bit
        end
    endtask

    initial begin
        o_frame          = '0;
        o_frame_count    = 0;
        o_byte_count     = 0;
        o_framing_errors = 0;
        o_in_frame       = 1'b0;
        frame_shift      = '0;
        byte_idx         = 0;
        forever begin
            @(negedge i_clock);
            if (i_reset) begin
                byte_idx   = 0;
                o_in_frame = 1'b0;
            end else if (i_rx === 1'b0) begin
                if (byte_idx == 0) begin
                    o_in_frame = 1'b1;
                end
                receive_byte(rx_byte, rx_ok);
                if (!rx_ok) begin
                    o_framing_errors++;
                end
                o_byte_count++;
                frame_shift = {frame_shift[FRAME_BYTES*8-9:0], rx_byte};
                if (byte_idx == FRAME_BYTES - 1) begin
                    byte_idx   = 0;
                    o_frame    = frame_shift;
                    o_in_frame = 1'b0;
                    o_frame_count++;
                end else begin
                    byte_idx++;
                end
            end
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module scope_tb \
    -f all.f \
    -o scope_sim

out=$(./obj_dir/scope_sim)
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: src/adc_capture.sv
module adc_capture
    import scope_pkg::*;
(
    input  logic     i_clock,
    input  logic     i_reset,

    input  adc_raw_t i_adc_data,
    input  logic     i_gate,

    output sample_t  o_sample,
    output logic     o_sample_valid
);

    adc_raw_t adc_data_q;   // Pad register
    logic     gate_q;
    sample_t  sample_q;
    logic     sample_valid_q;

    // First stage, straight off the pins
    always_ff @(posedge i_clock) begin
        adc_data_q <= i_adc_data;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            gate_q <= 1'b0;
        end else begin
            gate_q <= i_gate;
        end
    end

    // Second stage: offset binary to two's complement by flipping the MSB
    always_ff @(posedge i_clock) begin
        sample_q <= {~adc_data_q[ADC_WIDTH-1], adc_data_q[ADC_WIDTH-2:0]};
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            sample_valid_q <= 1'b0;
        end else begin
            sample_valid_q <= gate_q;   // Gate follows the data
        end
    end

    assign o_sample       = sample_q;
    assign o_sample_valid = sample_valid_q;

endmodule

// File: src/report_framer.sv
module report_framer
    import scope_pkg::*;
(
    input  logic   i_clock,
    input  logic   i_reset,

    input  stats_t i_stats,
    input  logic   i_stats_valid,

    input  logic   i_tx_busy,
    output byte_t  o_tx_byte,
    output logic   o_tx_load,

    output logic   o_sending,
    output logic   o_overflow
);

    localparam int IDX_W  = $clog2(FRAME_BYTES);
    localparam int WORD_W = 16;     // Values go out as 16-bit words

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        WAIT
    } state_t;

    state_t            state_q;
    logic [IDX_W-1:0]  idx_q;
    stats_t            stats_q;
    logic              overflow_q;

    logic [WORD_W-1:0] min_word;
    logic [WORD_W-1:0] max_word;
    logic [WORD_W-1:0] mean_word;
    byte_t             frame_byte;

    // Sign extension to the wire format
    assign min_word  = WORD_W'(stats_q.min_val);
    assign max_word  = WORD_W'(stats_q.max_val);
    assign mean_word = WORD_W'(stats_q.mean_val);

    always_comb begin
        case (idx_q)
            IDX_W'(0): frame_byte = FRAME_HEADER;
            IDX_W'(1): frame_byte = min_word[15:8];
            IDX_W'(2): frame_byte = min_word[7:0];
            IDX_W'(3): frame_byte = max_word[15:8];
            IDX_W'(4): frame_byte = max_word[7:0];
            IDX_W'(5): frame_byte = mean_word[15:8];
            default:   frame_byte = mean_word[7:0];
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= IDLE;
            idx_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_stats_valid) begin
                        idx_q   <= '0;
                        state_q <= LOAD;
                    end
                end
                LOAD: begin
                    if (!i_tx_busy) begin
                        state_q <= WAIT;
                    end
                end
                WAIT: begin
                    // Busy is already up in the first WAIT cycle
                    if (!i_tx_busy) begin
                        if (idx_q == IDX_W'(FRAME_BYTES - 1)) begin
                            state_q <= IDLE;
                        end else begin
                            idx_q   <= idx_q + 1'b1;
                            state_q <= LOAD;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Only one result in flight
    always_ff @(posedge i_clock) begin
        if (state_q == IDLE && i_stats_valid) begin
            stats_q <= i_stats;
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            overflow_q <= 1'b0;
        end else if (i_stats_valid && state_q != IDLE) begin
            overflow_q <= 1'b1;     // Sticky
        end
    end

    assign o_tx_byte  = frame_byte;
    assign o_tx_load  = (state_q == LOAD) && !i_tx_busy;
    assign o_sending  = (state_q != IDLE);
    assign o_overflow = overflow_q;

endmodule

// File: src/scope_pkg.sv
package scope_pkg;

    // ADC front end
    localparam int ADC_WIDTH = 14;

    // Offset-binary code as it comes off the ADC pins
    typedef logic [ADC_WIDTH-1:0] adc_raw_t;

    // Two's complement sample, 0 is mid-scale
    typedef logic signed [ADC_WIDTH-1:0] sample_t;

    // One window result
    typedef struct packed {
        sample_t min_val;
        sample_t max_val;
        sample_t mean_val;
    } stats_t;

    // UART side
    typedef logic [7:0] byte_t;

    // Frame is header, then min, max and mean as 16-bit words, MSB byte first
    localparam byte_t FRAME_HEADER = 8'hA5;
    localparam int FRAME_BYTES = 7;

endpackage

// File: src/scope_top.sv
module scope_top
    import scope_pkg::*;
#(
    parameter int WINDOW_LEN   = 16,
    parameter int CLKS_PER_BIT = 868
)
(
    input  logic     i_clock,
    input  logic     i_reset,

    input  logic     i_gate,
    input  adc_raw_t i_adc_data,

    output logic     o_tx_ch1,
    output logic     o_led0_r,
    output logic     o_led0_g,
    output logic     o_led0_b
);

    sample_t sample;
    logic    sample_valid;
    stats_t  stats;
    logic    stats_valid;
    byte_t   tx_byte;
    logic    tx_load;
    logic    tx_busy;
    logic    sending;
    logic    overflow;

    adc_capture u_adc_capture (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_adc_data     (i_adc_data),
        .i_gate         (i_gate),
        .o_sample       (sample),
        .o_sample_valid (sample_valid)
    );

    window_stats #(
        .WINDOW_LEN (WINDOW_LEN)
    ) u_window_stats (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .o_stats        (stats),
        .o_stats_valid  (stats_valid)
    );

    report_framer u_report_framer (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_stats       (stats),
        .i_stats_valid (stats_valid),
        .i_tx_busy     (tx_busy),
        .o_tx_byte     (tx_byte),
        .o_tx_load     (tx_load),
        .o_sending     (sending),
        .o_overflow    (overflow)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_data  (tx_byte),
        .i_load  (tx_load),
        .o_tx    (o_tx_ch1),
        .o_busy  (tx_busy)
    );

    // Status LEDs
    assign o_led0_r = overflow;
    assign o_led0_b = sending;
    assign o_led0_g = !overflow && !sending;    // All quiet

endmodule

// File: src/uart_tx.sv
module uart_tx
    import scope_pkg::*;
#(
    parameter int CLKS_PER_BIT = 868
)
(
    input  logic  i_clock,
    input  logic  i_reset,

    input  byte_t i_data,
    input  logic  i_load,

    output logic  o_tx,
    output logic  o_busy
);

    localparam int CNT_W   = $clog2(CLKS_PER_BIT + 1);
    localparam int FRAME_W = 10;    // Start, 8 data, stop

    logic [CNT_W-1:0]   clk_cnt_q;
    logic [3:0]         bit_idx_q;
    logic [FRAME_W-1:0] shift_q;
    logic               busy_q;
    logic               bit_done;

    assign bit_done = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            shift_q   <= '1;    // Line idles high
            busy_q    <= 1'b0;
            clk_cnt_q <= '0;
            bit_idx_q <= '0;
        end else if (!busy_q) begin
            if (i_load) begin
                shift_q   <= {1'b1, i_data, 1'b0};
                busy_q    <= 1'b1;
                clk_cnt_q <= '0;
                bit_idx_q <= '0;
            end
        end else if (bit_done) begin
            clk_cnt_q <= '0;
            shift_q   <= {1'b1, shift_q[FRAME_W-1:1]};   // LSB first
            if (bit_idx_q == 4'(FRAME_W - 1)) begin
                busy_q <= 1'b0;     // End of stop bit
            end else begin
                bit_idx_q <= bit_idx_q + 1'b1;
            end
        end else begin
            clk_cnt_q <= clk_cnt_q + 1'b1;
        end
    end

    assign o_tx   = shift_q[0];
    assign o_busy = busy_q;

endmodule

// File: src/window_stats.sv
module window_stats
    import scope_pkg::*;
#(
    parameter int WINDOW_LEN = 16
)
(
    input  logic    i_clock,
    input  logic    i_reset,

    input  sample_t i_sample,
    input  logic    i_sample_valid,

    output stats_t  o_stats,
    output logic    o_stats_valid
);

    localparam int WIN_SHIFT = $clog2(WINDOW_LEN);          // Mean is a plain shift
    localparam int CNT_W     = (WIN_SHIFT > 0) ? WIN_SHIFT : 1;
    localparam int SUM_W     = ADC_WIDTH + WIN_SHIFT;        // No overflow over a full window

    logic [CNT_W-1:0]       cnt_q;
    sample_t                min_q;
    sample_t                max_q;
    logic signed [SUM_W-1:0] sum_q;

    logic                    first;
    logic                    last;
    sample_t                 min_next;
    sample_t                 max_next;
    logic signed [SUM_W-1:0] sum_next;
    logic signed [SUM_W-1:0] mean_wide;

    stats_t                  stats_q;
    logic                    stats_valid_q;

    assign first = (cnt_q == '0);
    assign last  = (cnt_q == CNT_W'(WINDOW_LEN - 1));

    // Running values including the current sample
    always_comb begin
        if (first) begin
            min_next = i_sample;
            max_next = i_sample;
            sum_next = SUM_W'(i_sample);
        end else begin
            min_next = (i_sample < min_q) ? i_sample : min_q;
            max_next = (i_sample > max_q) ? i_sample : max_q;
            sum_next = sum_q + SUM_W'(i_sample);
        end
        mean_wide = sum_next >>> WIN_SHIFT;     // Floor, sign kept
    end

    // Sample count, held while the gate is low
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            cnt_q <= '0;
        end else if (i_sample_valid) begin
            if (last) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_sample_valid) begin
            min_q <= min_next;
            max_q <= max_next;
            sum_q <= sum_next;
        end
    end

    // Result register
    always_ff @(posedge i_clock) begin
        if (i_sample_valid && last) begin
            stats_q.min_val  <= min_next;
            stats_q.max_val  <= max_next;
            stats_q.mean_val <= mean_wide[ADC_WIDTH-1:0];
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            stats_valid_q <= 1'b0;
        end else begin
            stats_valid_q <= i_sample_valid && last;    // One-cycle strobe
        end
    end

    assign o_stats       = stats_q;
    assign o_stats_valid = stats_valid_q;

endmodule
